// File: common/nr_pkg.sv
package nr_pkg;

    // cell ID range 0..1007
    localparam int N_ID_W = 10;

    // one candidate DMRS sequence per SSB index ibar
    localparam int NUM_IBAR = 8;
    localparam int IBAR_W   = 3;

    // length-31 Gold sequence, first 1600 bits are discarded
    localparam int GOLD_N  = 31;
    localparam int GOLD_NC = 1600;

    // PBCH symbol layout
    localparam int FFT_LEN       = 256;
    localparam int PILOT_SPACING = 4;
    localparam int NUM_PILOTS    = 64;

    // signed correlator width, 64 pilots x 2 bits gives +-128
    localparam int CORR_W = 9;

    // DMRS generator FSM
    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_LOAD,
        GEN_SKIP,
        GEN_FILL,
        GEN_DONE
    } gen_state_e;

    // ibar detector FSM
    typedef enum logic [1:0] {
        DET_IDLE,
        DET_ACCUM,
        DET_DECIDE
    } det_state_e;

endpackage

// File: common/stream_pkg.sv
package stream_pkg;

    // complex sample, re sits in the low half
    typedef struct packed {
        logic signed [15:0] im;
        logic signed [15:0] re;
    } iq_sample_t;

    // start marks subcarrier 0 of a PBCH symbol
    typedef struct packed {
        iq_sample_t iq;
        logic       start;
        logic       valid;
    } sample_in_t;

    // bit 1 is c(2m), bit 0 is c(2m+1)
    typedef logic [1:0] dmrs_pair_t;

    // one pair per candidate, indexed by ibar
    typedef dmrs_pair_t [nr_pkg::NUM_IBAR-1:0] dmrs_set_t;

    // store write, pair m of all candidates at once
    typedef struct packed {
        logic                                  valid;
        logic [$clog2(nr_pkg::NUM_PILOTS)-1:0] addr;
        dmrs_set_t                             pairs;
    } dmrs_wr_t;

endpackage

// File: hw/dmrs_gen/gold_lfsr.sv
module gold_lfsr (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      load_i,
    input  logic [nr_pkg::GOLD_N-1:0] c_init_i,
    output logic                      c_o
);

    logic [nr_pkg::GOLD_N-1:0] x1_q;
    logic [nr_pkg::GOLD_N-1:0] x2_q;

    // bit k holds x(n+k), new bit enters at the top
    // x1 always starts from a single one in the lowest position
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x1_q <= {{(nr_pkg::GOLD_N - 1){1'b0}}, 1'b1};
            x2_q <= '0;
        end else if (load_i) begin
            x1_q <= {{(nr_pkg::GOLD_N - 1){1'b0}}, 1'b1};
            x2_q <= c_init_i;
        end else begin
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[nr_pkg::GOLD_N-1:1]};
            x2_q <= {x2_q[3] ^ x2_q[2] ^ x2_q[1] ^ x2_q[0], x2_q[nr_pkg::GOLD_N-1:1]};
        end
    end

    assign c_o = x1_q[0] ^ x2_q[0];

endmodule

// File: hw/dmrs_gen/dmrs_generator.sv
module dmrs_generator (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic [nr_pkg::N_ID_W-1:0] n_id_i,
    input  logic                      n_id_valid_i,
    output stream_pkg::dmrs_wr_t      wr_o,
    output logic                      dmrs_ready_o,
    output logic [1:0]                pilot_offset_o
);

    nr_pkg::gen_state_e state_q;

    logic [10:0]                       cnt_q;
    logic [nr_pkg::N_ID_W-1:0]         n_id_q;
    logic [nr_pkg::GOLD_N-1:0]         n_div4_p1;
    logic [nr_pkg::GOLD_N-1:0]         c_init [nr_pkg::NUM_IBAR];
    logic [nr_pkg::NUM_IBAR-1:0]       c_bits;
    logic [nr_pkg::NUM_IBAR-1:0]       even_q;
    logic                              wr_vld_q;
    logic [5:0]                        wr_addr_q;
    stream_pkg::dmrs_set_t             wr_pairs_q;

    // floor(N_id / 4) + 1, shared by all candidates
    assign n_div4_p1 = {{(nr_pkg::GOLD_N - nr_pkg::N_ID_W + 2){1'b0}},
                        n_id_q[nr_pkg::N_ID_W-1:2]} + {{(nr_pkg::GOLD_N - 1){1'b0}}, 1'b1};

    for (genvar g = 0; g < nr_pkg::NUM_IBAR; g++) begin : gen_gold
        localparam logic [nr_pkg::GOLD_N-1:0] IBAR_P1 = g + 1;

        // 2048*(i+1)*(floor(N_id/4)+1) + 64*(i+1) + N_id mod 4
        assign c_init[g] = ((IBAR_P1 * n_div4_p1) << 11) + (IBAR_P1 << 6)
                         + {{(nr_pkg::GOLD_N - 2){1'b0}}, n_id_q[1:0]};

        gold_lfsr i_gold (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .load_i   (state_q == nr_pkg::GEN_LOAD),
            .c_init_i (c_init[g]),
            .c_o      (c_bits[g])
        );
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= nr_pkg::GEN_IDLE;
            cnt_q        <= '0;
            wr_vld_q     <= 1'b0;
            dmrs_ready_o <= 1'b0;
        end else begin
            wr_vld_q <= 1'b0;
            case (state_q)
                nr_pkg::GEN_LOAD: begin
                    cnt_q   <= '0;
                    state_q <= nr_pkg::GEN_SKIP;
                end
                nr_pkg::GEN_SKIP: begin
                    if (cnt_q == 11'(nr_pkg::GOLD_NC - 1)) begin
                        cnt_q   <= '0;
                        state_q <= nr_pkg::GEN_FILL;
                    end else begin
                        cnt_q <= cnt_q + 11'd1;
                    end
                end
                nr_pkg::GEN_FILL: begin
                    // odd cycles complete a pair
                    cnt_q    <= cnt_q + 11'd1;
                    wr_vld_q <= cnt_q[0];
                    if (cnt_q == 11'(2 * nr_pkg::NUM_PILOTS - 1)) begin
                        state_q <= nr_pkg::GEN_DONE;
                    end
                end
                nr_pkg::GEN_DONE: begin
                    dmrs_ready_o <= 1'b1;
                end
                default: begin
                end
            endcase
            // a new cell ID restarts from any state
            if (n_id_valid_i) begin
                state_q      <= nr_pkg::GEN_LOAD;
                wr_vld_q     <= 1'b0;
                dmrs_ready_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            n_id_q <= n_id_i;
        end
        if (state_q == nr_pkg::GEN_FILL) begin
            if (!cnt_q[0]) begin
                even_q <= c_bits;
            end
            wr_addr_q <= cnt_q[6:1];
            for (int i = 0; i < nr_pkg::NUM_IBAR; i++) begin
                wr_pairs_q[i] <= {even_q[i], c_bits[i]};
            end
        end
    end

    assign wr_o           = '{valid: wr_vld_q, addr: wr_addr_q, pairs: wr_pairs_q};
    assign pilot_offset_o = n_id_q[1:0];

endmodule

// File: hw/dmrs_store.sv
module dmrs_store (
    input  logic                  clk_i,
    input  stream_pkg::dmrs_wr_t  wr_i,
    input  logic [5:0]            rd_addr_i,
    output stream_pkg::dmrs_set_t rd_set_o
);

    // one entry per pilot, each entry holds all eight candidates
    stream_pkg::dmrs_set_t mem_q [nr_pkg::NUM_PILOTS];

    always_ff @(posedge clk_i) begin
        if (wr_i.valid) begin
            mem_q[wr_i.addr] <= wr_i.pairs;
        end
    end

    // registered read, data follows the address by one cycle
    always_ff @(posedge clk_i) begin
        rd_set_o <= mem_q[rd_addr_i];
    end

endmodule

// File: hw/ibar_detector.sv
module ibar_detector (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  stream_pkg::sample_in_t    sample_i,
    input  logic                      dmrs_ready_i,
    input  logic [1:0]                pilot_offset_i,
    output logic [5:0]                rd_addr_o,
    input  stream_pkg::dmrs_set_t     rd_set_i,
    output logic [nr_pkg::IBAR_W-1:0] ibar_o,
    output logic                      ibar_valid_o
);

    nr_pkg::det_state_e state_q;

    logic [7:0]                       sc_cnt_q;
    logic [5:0]                       pil_cnt_q;
    logic [1:0]                       off_q;
    logic                             first;
    logic                             take;
    logic                             is_pilot;
    logic                             decide_fire;
    logic [1:0]                       off;
    logic [1:0]                       k_lo;
    logic [1:0]                       pair_q;
    logic [1:0]                       pair_rot_q;
    logic                             pv_q;
    logic signed [nr_pkg::CORR_W-1:0] corr_q     [nr_pkg::NUM_IBAR];
    logic signed [nr_pkg::CORR_W-1:0] corr_rot_q [nr_pkg::NUM_IBAR];
    logic [nr_pkg::CORR_W-1:0]        abs_c      [nr_pkg::NUM_IBAR];
    logic [nr_pkg::CORR_W-1:0]        abs_r      [nr_pkg::NUM_IBAR];
    logic [nr_pkg::CORR_W-1:0]        score_q    [nr_pkg::NUM_IBAR];
    logic                             score_vld_q;
    logic [nr_pkg::IBAR_W-1:0]        best_idx;
    logic [nr_pkg::CORR_W-1:0]        best_val;

    // +2, 0 or -2 depending on how many of the two bits agree
    function automatic logic signed [nr_pkg::CORR_W-1:0] pair_corr(
        input logic [1:0] rx,
        input logic [1:0] ref_pair
    );
        logic signed [nr_pkg::CORR_W-1:0] d;
        case (rx ^ ref_pair)
            2'b00:   d = {{(nr_pkg::CORR_W - 2){1'b0}}, 2'b10};
            2'b11:   d = {{(nr_pkg::CORR_W - 1){1'b1}}, 1'b0};
            default: d = '0;
        endcase
        return d;
    endfunction

    // the start sample itself is subcarrier 0
    assign first = (state_q == nr_pkg::DET_IDLE) && sample_i.valid && sample_i.start
                   && dmrs_ready_i;
    assign take  = first || ((state_q == nr_pkg::DET_ACCUM) && sample_i.valid);
    assign off   = first ? pilot_offset_i : off_q;
    // subcarrier count rests at zero while idle
    assign k_lo  = sc_cnt_q[1:0];
    assign is_pilot = take && (((k_lo - off) & 2'(nr_pkg::PILOT_SPACING - 1)) == 2'd0);
    assign decide_fire = (state_q == nr_pkg::DET_DECIDE) && sc_cnt_q[0];
    assign rd_addr_o   = pil_cnt_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= nr_pkg::DET_IDLE;
            sc_cnt_q    <= '0;
            pil_cnt_q   <= '0;
            pv_q        <= 1'b0;
            score_vld_q <= 1'b0;
        end else begin
            pv_q        <= is_pilot;
            score_vld_q <= 1'b0;
            if (is_pilot) begin
                pil_cnt_q <= pil_cnt_q + 6'd1;
            end
            case (state_q)
                nr_pkg::DET_IDLE: begin
                    if (first) begin
                        sc_cnt_q <= 8'd1;
                        state_q  <= nr_pkg::DET_ACCUM;
                    end
                end
                nr_pkg::DET_ACCUM: begin
                    if (take) begin
                        sc_cnt_q <= sc_cnt_q + 8'd1;
                        if (sc_cnt_q == 8'(nr_pkg::FFT_LEN - 1)) begin
                            state_q <= nr_pkg::DET_DECIDE;
                        end
                    end
                end
                default: begin
                    // first DECIDE cycle lets the last pilot reach the correlators
                    if (!sc_cnt_q[0]) begin
                        sc_cnt_q <= 8'd1;
                    end else begin
                        sc_cnt_q    <= '0;
                        pil_cnt_q   <= '0;
                        score_vld_q <= 1'b1;
                        state_q     <= nr_pkg::DET_IDLE;
                    end
                end
            endcase
        end
    end

    // hard demodulation, held one cycle to line up with the store read
    always_ff @(posedge clk_i) begin
        if (take) begin
            off_q      <= off;
            pair_q     <= {sample_i.iq.re[15], sample_i.iq.im[15]};
            pair_rot_q <= {~sample_i.iq.im[15], sample_i.iq.re[15]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni || decide_fire) begin
            for (int i = 0; i < nr_pkg::NUM_IBAR; i++) begin
                corr_q[i]     <= '0;
                corr_rot_q[i] <= '0;
            end
        end else if (pv_q) begin
            for (int i = 0; i < nr_pkg::NUM_IBAR; i++) begin
                corr_q[i]     <= corr_q[i] + pair_corr(pair_q, rd_set_i[i]);
                corr_rot_q[i] <= corr_rot_q[i] + pair_corr(pair_rot_q, rd_set_i[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < nr_pkg::NUM_IBAR; i++) begin
            abs_c[i] = corr_q[i][nr_pkg::CORR_W-1] ? -corr_q[i] : corr_q[i];
            abs_r[i] = corr_rot_q[i][nr_pkg::CORR_W-1] ? -corr_rot_q[i] : corr_rot_q[i];
        end
    end

    // score is the better of the two phase hypotheses
    always_ff @(posedge clk_i) begin
        if (decide_fire) begin
            for (int i = 0; i < nr_pkg::NUM_IBAR; i++) begin
                score_q[i] <= (abs_r[i] > abs_c[i]) ? abs_r[i] : abs_c[i];
            end
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_idx = '0;
        best_val = score_q[0];
        for (int i = 1; i < nr_pkg::NUM_IBAR; i++) begin
            if (score_q[i] > best_val) begin
                best_val = score_q[i];
                best_idx = i[nr_pkg::IBAR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ibar_valid_o <= 1'b0;
        end else begin
            ibar_valid_o <= score_vld_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (score_vld_q) begin
            ibar_o <= best_idx;
        end
    end

endmodule

// File: hw/pbch_ibar_top.sv
module pbch_ibar_top (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic [nr_pkg::N_ID_W-1:0] n_id_i,
    input  logic                      n_id_valid_i,
    input  stream_pkg::sample_in_t    sample_i,
    output logic                      dmrs_ready_o,
    output logic [nr_pkg::IBAR_W-1:0] ibar_o,
    output logic                      ibar_valid_o
);

    stream_pkg::dmrs_wr_t  dmrs_wr;
    stream_pkg::dmrs_set_t rd_set;
    logic [5:0]            rd_addr;
    logic [1:0]            pilot_offset;

    // builds all eight candidate sequences after each cell ID
    dmrs_generator i_dmrs_generator (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .wr_o           (dmrs_wr),
        .dmrs_ready_o   (dmrs_ready_o),
        .pilot_offset_o (pilot_offset)
    );

    dmrs_store i_dmrs_store (
        .clk_i     (clk_i),
        .wr_i      (dmrs_wr),
        .rd_addr_i (rd_addr),
        .rd_set_o  (rd_set)
    );

    ibar_detector i_ibar_detector (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .dmrs_ready_i   (dmrs_ready_o),
        .pilot_offset_i (pilot_offset),
        .rd_addr_o      (rd_addr),
        .rd_set_i       (rd_set),
        .ibar_o         (ibar_o),
        .ibar_valid_o   (ibar_valid_o)
    );

endmodule

// File: tb/pbch_ibar_asserts.sv
module pbch_ibar_asserts (
    input logic                 clk_i,
    input logic                 reset_ni,
    input logic                 ibar_valid_o,
    input logic                 dmrs_ready_o,
    input stream_pkg::dmrs_wr_t wr_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // result strobe is a single-cycle pulse
    valid_single_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o)
        else $error("ibar_valid_o high on two consecutive cycles");

    // no result during reset or in the cycle right after it
    valid_quiet_after_reset: assert property (@(posedge clk_i)
        (!reset_ni || $past(!reset_ni)) |=> !ibar_valid_o)
        else $error("ibar_valid_o high within one cycle of reset");

    // the store is frozen once the candidates are complete
    no_write_when_ready: assert property (@(posedge clk_i) disable iff (!reset_ni)
        dmrs_ready_o |-> !wr_i.valid)
        else $error("store write while dmrs_ready_o is high");

endmodule

// File: tb/tb_pbch_ibar.sv
module tb_pbch_ibar;

    timeunit 1ns;
    timeprecision 1ps;

    logic                      clk_i;
    logic                      reset_ni;
    logic [nr_pkg::N_ID_W-1:0] n_id_i;
    logic                      n_id_valid_i;
    stream_pkg::sample_in_t    sample_i;
    logic                      dmrs_ready_o;
    logic [nr_pkg::IBAR_W-1:0] ibar_o;
    logic                      ibar_valid_o;

    // expected candidate sequences, bit n holds c(n)
    logic [127:0] ref_c [8];
    int           cur_off;
    logic [31:0]  lfsr_q = 32'hcd7c6c9e;
    int           cyc = 0;
    int           checks = 0;
    int           errors = 0;
    int           n_results = 0;
    logic [2:0]   exp_ibar_q [$];
    int           exp_cyc_q [$];

    pbch_ibar_top i_dut (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .sample_i     (sample_i),
        .dmrs_ready_o (dmrs_ready_o),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

    bind pbch_ibar_top pbch_ibar_asserts i_asserts (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .ibar_valid_o (ibar_valid_o),
        .dmrs_ready_o (dmrs_ready_o),
        .wr_i         (dmrs_wr)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [30:0] c_init_of(input int n_id, input int i);
        return 31'(2048 * (i + 1) * (n_id / 4 + 1) + 64 * (i + 1) + n_id % 4);
    endfunction

    // c(n) for n = 0..127 after dropping the first 1600 outputs
    function automatic logic [127:0] gold_bits(input logic [30:0] c_init);
        logic         x1 [0:1758];
        logic         x2 [0:1758];
        logic [127:0] c;
        for (int n = 0; n < 31; n++) begin
            x1[n] = (n == 0);
            x2[n] = c_init[n];
        end
        for (int n = 0; n < 1728; n++) begin
            x1[n+31] = x1[n+3] ^ x1[n];
            x2[n+31] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
        end
        for (int n = 0; n < 128; n++) begin
            c[n] = x1[n+1600] ^ x2[n+1600];
        end
        return c;
    endfunction

    // highest max(|unrotated|, |rotated|) correlation, lowest index on a tie
    function automatic logic [2:0] best_ibar(input logic [127:0] rx);
        int         u;
        int         r;
        int         s;
        int         best_s;
        logic [1:0] p;
        logic [1:0] pr;
        logic [1:0] q;
        logic [2:0] best;
        best = '0;
        best_s = -1;
        for (int i = 0; i < 8; i++) begin
            u = 0;
            r = 0;
            for (int m = 0; m < 64; m++) begin
                p  = rx[2*m +: 2];
                pr = {~p[0], p[1]};
                q  = {ref_c[i][2*m], ref_c[i][2*m+1]};
                for (int b = 0; b < 2; b++) begin
                    u += (p[b] == q[b]) ? 1 : -1;
                    r += (pr[b] == q[b]) ? 1 : -1;
                end
            end
            u = (u < 0) ? -u : u;
            r = (r < 0) ? -r : r;
            s = (r > u) ? r : u;
            if (s > best_s) begin
                best_s = s;
                best = 3'(i);
            end
        end
        return best;
    endfunction

    task automatic set_n_id(input int n_id);
        n_id_i = 10'(n_id);
        n_id_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        n_id_valid_i = 1'b0;
        for (int i = 0; i < 8; i++) begin
            ref_c[i] = gold_bits(c_init_of(n_id, i));
        end
        cur_off = n_id % 4;
    endtask

    task automatic wait_ready(input logic level, input int limit);
        int t;
        t = 0;
        while (dmrs_ready_o !== level && t < limit) begin
            @(posedge clk_i);
            #2;
            t++;
        end
        checks++;
        if (dmrs_ready_o !== level) begin
            $display("timeout: dmrs_ready_o did not reach %0d within %0d cycles", level, limit);
            errors++;
        end
    endtask

    // one PBCH symbol, pilots carry the pairs of candidate cand
    task automatic send_symbol(input int cand, input bit rot, input bit gaps, input int n_bad);
        logic [127:0] tx;
        logic [127:0] rx;
        logic [1:0]   p;
        logic         s_re;
        logic         s_im;
        int           m;
        int           e_take;
        for (m = 0; m < 64; m++) begin
            tx[2*m +: 2] = {ref_c[cand][2*m], ref_c[cand][2*m+1]};
        end
        for (int j = 0; j < n_bad; j++) begin
            m = int'(rand_bits(6));
            p = 2'(rand_bits(2));
            if (p == 2'b00) begin
                p = 2'b11;
            end
            tx[2*m +: 2] ^= p;
        end
        for (int k = 0; k < 256; k++) begin
            if (gaps && rand_bits(2) == 0) begin
                sample_i.valid = 1'b0;
                repeat (int'(rand_bits(2)) + 1) begin
                    @(posedge clk_i);
                    #2;
                end
            end
            if (((k - cur_off) & 3) == 0) begin
                m = k >> 2;
                p = tx[2*m +: 2];
                // a 90 degree turn maps (re, im) to (-im, re)
                s_re = rot ? ~p[0] : p[1];
                s_im = rot ? p[1] : p[0];
                rx[2*m +: 2] = {s_re, s_im};
            end else begin
                s_re = rand_bits(1) != 0;
                s_im = rand_bits(1) != 0;
            end
            sample_i.iq.re = {s_re, 15'(rand_bits(15))};
            sample_i.iq.im = {s_im, 15'(rand_bits(15))};
            sample_i.start = (k == 0);
            sample_i.valid = 1'b1;
            if (k == 255) begin
                e_take = cyc + 1;
            end
            @(posedge clk_i);
            #2;
        end
        sample_i = '0;
        exp_ibar_q.push_back(best_ibar(rx));
        exp_cyc_q.push_back(e_take + 3);
    endtask

    task automatic wait_result(input int n_before);
        int t;
        t = 0;
        while (n_results == n_before && t < 20) begin
            @(posedge clk_i);
            #2;
            t++;
        end
        if (n_results == n_before) begin
            $display("timeout: no ibar_valid_o after the symbol");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s: %s", name, (errors == err_before) ? "pass" : "FAIL");
    endtask

    // compares each result strobe with the oldest expectation
    initial begin
        logic [2:0] e_ibar;
        int         e_cyc;
        forever begin
            @(negedge clk_i);
            if (reset_ni && ibar_valid_o) begin
                if (exp_ibar_q.size() == 0) begin
                    $display("ibar_valid_o pulsed with no symbol pending");
                    errors++;
                end else begin
                    e_ibar = exp_ibar_q.pop_front();
                    e_cyc = exp_cyc_q.pop_front();
                    checks += 2;
                    if (ibar_o !== e_ibar) begin
                        $display("** Error: ibar_o = 0x%0h, expected 0x%0h", ibar_o, e_ibar);
                        errors++;
                    end
                    if (cyc != e_cyc) begin
                        $display("** Error: ibar_valid_o cycle = 0x%0h, expected 0x%0h",
                                 cyc, e_cyc);
                        errors++;
                    end
                end
                n_results++;
            end
        end
    end

    initial begin
        int eb;
        int nb;
        reset_ni = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        sample_i = '0;
        repeat (3) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;

        // a whole symbol led by a start sample before any cell ID must be ignored
        eb = errors;
        for (int k = 0; k < 300; k++) begin
            if (k < 256) begin
                sample_i.start = (k == 0);
                sample_i.valid = 1'b1;
            end else begin
                sample_i = '0;
            end
            @(posedge clk_i);
            #2;
            checks += 2;
            if (dmrs_ready_o !== 1'b0) begin
                $display("** Error: dmrs_ready_o = 0x%0h, expected 0x0", dmrs_ready_o);
                errors++;
            end
            if (ibar_valid_o !== 1'b0) begin
                $display("** Error: ibar_valid_o = 0x%0h, expected 0x0", ibar_valid_o);
                errors++;
            end
        end
        report_test("idle after reset", eb);

        eb = errors;
        set_n_id(341);
        wait_ready(1'b1, 2000);
        for (int c = 0; c < 8; c++) begin
            nb = n_results;
            send_symbol(c, 1'b0, 1'b0, 0);
            wait_result(nb);
        end
        report_test("ibar sweep", eb);

        eb = errors;
        for (int c = 0; c < 8; c++) begin
            nb = n_results;
            send_symbol(c, 1'b1, 1'b1, 0);
            wait_result(nb);
        end
        report_test("rotated with gaps", eb);

        eb = errors;
        nb = n_results;
        send_symbol(5, 1'b0, 1'b0, 6);
        wait_result(nb);
        report_test("corrupted pilots", eb);

        eb = errors;
        set_n_id(1006);
        wait_ready(1'b0, 3);
        wait_ready(1'b1, 2000);
        nb = n_results;
        send_symbol(3, 1'b0, 1'b0, 0);
        wait_result(nb);
        report_test("new cell ID", eb);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
common/nr_pkg.sv
common/stream_pkg.sv
hw/dmrs_gen/gold_lfsr.sv
hw/dmrs_gen/dmrs_generator.sv
hw/dmrs_store.sv
hw/ibar_detector.sv
hw/pbch_ibar_top.sv
tb/pbch_ibar_asserts.sv
tb/tb_pbch_ibar.sv

// File: Makefile
TOP = tb_pbch_ibar

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
